//--- verilog/axil_pkg.sv
`default_nettype none

package axil_pkg;

  localparam int AW = 16;  // byte address width
  localparam int DW = 32;  // data width

  // response codes, only the two used here
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axil_resp_e;

  // master driven side
  typedef struct packed {
    logic [AW-1:0]   awaddr;
    logic            awvalid;
    logic [DW-1:0]   wdata;
    logic [DW/8-1:0] wstrb;
    logic            wvalid;
    logic            bready;
    logic [AW-1:0]   araddr;
    logic            arvalid;
    logic            rready;
  } axil_req_t;

  // slave driven side
  typedef struct packed {
    logic          awready;
    logic          wready;
    axil_resp_e    bresp;
    logic          bvalid;
    logic          arready;
    logic [DW-1:0] rdata;
    axil_resp_e    rresp;
    logic          rvalid;
  } axil_rsp_t;

endpackage

`default_nettype wire

//--- verilog/asg_pkg.sv
`default_nettype none

package asg_pkg;

  localparam int DWO = 14;         // sample width, signed
  localparam int CWM = 10;         // pointer integer part, 1024 entries
  localparam int CWF = 16;         // pointer fraction part
  localparam int CW  = CWM + CWF;  // full fixed point pointer

  // table window, one sample per 32 bit word
  localparam logic [axil_pkg::AW-1:0] BUF_BASE = 16'h1000;

  // register map, byte offsets
  typedef enum logic [axil_pkg::AW-1:0] {
    REG_CTRL = 16'h0000,  // bit0 trigger, bit1 clear (pulses)
    REG_MODE = 16'h0004,  // bit0 burst, bit1 infinite
    REG_SIZE = 16'h0008,
    REG_STEP = 16'h000c,
    REG_OFFS = 16'h0010,
    REG_NCYC = 16'h0014,  // samples per burst - 1
    REG_RNUM = 16'h0018,  // repetitions
    REG_RDLY = 16'h001c   // delay between bursts
  } reg_addr_e;

  typedef enum logic [1:0] {
    ST_IDLE  = 2'b00,
    ST_DATA  = 2'b01,
    ST_DELAY = 2'b10
  } asg_state_e;

  // channel configuration
  typedef struct packed {
    logic [CW-1:0] size;  // table size, fixed point
    logic [CW-1:0] step;  // pointer step
    logic [CW-1:0] offs;  // start offset (phase)
    logic          brst;
    logic          infn;
    logic [15:0]   ncyc;
    logic [15:0]   rnum;
    logic [31:0]   rdly;
  } asg_cfg_t;

  // cpu side table port
  typedef struct packed {
    logic           ena;
    logic           wen;
    logic [CWM-1:0] addr;
    logic [DWO-1:0] wdata;
  } buf_req_t;

endpackage

`default_nettype wire

//--- verilog/asg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module asg_regs (
  input  logic                           clk,
  input  logic                           ctl_rst,
  input  axil_pkg::axil_req_t            s_axil_req,
  output axil_pkg::axil_rsp_t            s_axil_rsp,
  output asg_pkg::asg_cfg_t              cfg,
  output logic                           sw_trg,
  output logic                           sw_clr,
  output asg_pkg::buf_req_t              buf_req,
  input  logic signed [asg_pkg::DWO-1:0] buf_rdata
);

  // write channel
  logic                   aw_rdy;   // aw and w accepted together
  logic                   wr_acc;
  logic                   bvalid;
  axil_pkg::axil_resp_e   bresp;
  logic [axil_pkg::DW-1:0] wr_val;  // strobe merged write value
  // read channel
  logic                   ar_rdy;
  logic                   ar_hs;
  logic                   rd_wait;  // table read, waiting on ram
  logic                   rvalid;
  logic [axil_pkg::DW-1:0] rdata;
  axil_pkg::axil_resp_e   rresp;

  //////////////////////////////////////////////////////////////////////
  // address decode helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic in_buf(input logic [axil_pkg::AW-1:0] a);
    return a[axil_pkg::AW-1:asg_pkg::CWM+2] == asg_pkg::BUF_BASE[axil_pkg::AW-1:asg_pkg::CWM+2];
  endfunction

  function automatic logic reg_hit(input logic [axil_pkg::AW-1:0] a);
    return a inside {asg_pkg::REG_CTRL, asg_pkg::REG_MODE, asg_pkg::REG_SIZE,
                     asg_pkg::REG_STEP, asg_pkg::REG_OFFS, asg_pkg::REG_NCYC,
                     asg_pkg::REG_RNUM, asg_pkg::REG_RDLY};
  endfunction

  // register read mux, ctrl reads as zero
  function automatic logic [axil_pkg::DW-1:0] reg_rd(input asg_pkg::asg_cfg_t c,
                                                      input logic [axil_pkg::AW-1:0] a);
    logic [axil_pkg::DW-1:0] v;
    v = '0;
    case (a)
      asg_pkg::REG_MODE: v = {30'd0, c.infn, c.brst};
      asg_pkg::REG_SIZE: v = 32'(c.size);
      asg_pkg::REG_STEP: v = 32'(c.step);
      asg_pkg::REG_OFFS: v = 32'(c.offs);
      asg_pkg::REG_NCYC: v = 32'(c.ncyc);
      asg_pkg::REG_RNUM: v = 32'(c.rnum);
      asg_pkg::REG_RDLY: v = c.rdly;
      default:           v = '0;
    endcase
    return v;
  endfunction

  function automatic logic [axil_pkg::DW-1:0] strb_merge(
    input logic [axil_pkg::DW-1:0]   old_v,
    input logic [axil_pkg::DW-1:0]   new_v,
    input logic [axil_pkg::DW/8-1:0] strb
  );
    logic [axil_pkg::DW-1:0] v;
    v = old_v;
    for (int i = 0; i < axil_pkg::DW/8; i++) begin
      if (strb[i]) v[8*i +: 8] = new_v[8*i +: 8];
    end
    return v;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // write path
  //////////////////////////////////////////////////////////////////////

  assign wr_acc = aw_rdy & s_axil_req.awvalid & s_axil_req.wvalid;
  assign wr_val = strb_merge(reg_rd(cfg, s_axil_req.awaddr), s_axil_req.wdata,
                             s_axil_req.wstrb);

  always_ff @(posedge clk) begin
    if (ctl_rst) begin
      aw_rdy <= 1'b0;
      bvalid <= 1'b0;
    end else begin
      // one cycle ready, only with no response pending
      aw_rdy <= ~aw_rdy & ~bvalid & s_axil_req.awvalid & s_axil_req.wvalid;
      if (wr_acc) bvalid <= 1'b1;
      else if (s_axil_req.bready) bvalid <= 1'b0;  // hold until taken
    end
  end

  always_ff @(posedge clk) begin
    if (wr_acc) begin
      bresp <= (reg_hit(s_axil_req.awaddr) || in_buf(s_axil_req.awaddr)) ?
               axil_pkg::OKAY : axil_pkg::SLVERR;
    end
  end

  // configuration registers
  always_ff @(posedge clk) begin
    if (ctl_rst) begin
      cfg <= '0;
    end else if (wr_acc) begin
      case (s_axil_req.awaddr)
        asg_pkg::REG_MODE: begin
          cfg.brst <= wr_val[0];
          cfg.infn <= wr_val[1];
        end
        asg_pkg::REG_SIZE: cfg.size <= wr_val[asg_pkg::CW-1:0];
        asg_pkg::REG_STEP: cfg.step <= wr_val[asg_pkg::CW-1:0];
        asg_pkg::REG_OFFS: cfg.offs <= wr_val[asg_pkg::CW-1:0];
        asg_pkg::REG_NCYC: cfg.ncyc <= wr_val[15:0];
        asg_pkg::REG_RNUM: cfg.rnum <= wr_val[15:0];
        asg_pkg::REG_RDLY: cfg.rdly <= wr_val;
        default: ;  // ctrl and table handled elsewhere
      endcase
    end
  end

  // ctrl pulses, one cycle after accept
  always_ff @(posedge clk) begin
    if (ctl_rst) begin
      sw_trg <= 1'b0;
      sw_clr <= 1'b0;
    end else begin
      sw_trg <= wr_acc && s_axil_req.awaddr == asg_pkg::REG_CTRL && wr_val[0];
      sw_clr <= wr_acc && s_axil_req.awaddr == asg_pkg::REG_CTRL && wr_val[1];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read path
  //////////////////////////////////////////////////////////////////////

  assign ar_hs = ar_rdy & ~aw_rdy & s_axil_req.arvalid;  // write owns the ram port first

  always_ff @(posedge clk) begin
    if (ctl_rst) begin
      ar_rdy  <= 1'b0;
      rd_wait <= 1'b0;
      rvalid  <= 1'b0;
    end else if (ar_hs) begin
      ar_rdy <= 1'b0;
      if (in_buf(s_axil_req.araddr)) rd_wait <= 1'b1;
      else rvalid <= 1'b1;                             // registers answer next cycle
    end else if (rd_wait) begin
      rd_wait <= 1'b0;
      rvalid  <= 1'b1;
    end else if (rvalid) begin
      if (s_axil_req.rready) begin
        rvalid <= 1'b0;
        ar_rdy <= 1'b1;
      end
    end else begin
      ar_rdy <= 1'b1;  // idle
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      rdata <= reg_rd(cfg, s_axil_req.araddr);
      rresp <= (reg_hit(s_axil_req.araddr) || in_buf(s_axil_req.araddr)) ?
               axil_pkg::OKAY : axil_pkg::SLVERR;
    end else if (rd_wait) begin
      rdata <= 32'(buf_rdata);  // sign extended sample
    end
  end

  // single cpu port into the table
  always_comb begin
    buf_req = '0;
    if (wr_acc && in_buf(s_axil_req.awaddr)) begin
      buf_req.ena   = 1'b1;
      buf_req.wen   = 1'b1;
      buf_req.addr  = s_axil_req.awaddr[2 +: asg_pkg::CWM];
      buf_req.wdata = s_axil_req.wdata[asg_pkg::DWO-1:0];
    end else if (ar_hs && in_buf(s_axil_req.araddr)) begin
      buf_req.ena  = 1'b1;
      buf_req.addr = s_axil_req.araddr[2 +: asg_pkg::CWM];
    end
  end

  always_comb begin
    s_axil_rsp.awready = aw_rdy;
    s_axil_rsp.wready  = aw_rdy;
    s_axil_rsp.bresp   = bresp;
    s_axil_rsp.bvalid  = bvalid;
    s_axil_rsp.arready = ar_rdy & ~aw_rdy;
    s_axil_rsp.rdata   = rdata;
    s_axil_rsp.rresp   = rresp;
    s_axil_rsp.rvalid  = rvalid;
  end

endmodule

`default_nettype wire

//--- verilog/asg_chan.sv
`timescale 1ns/1ps
`default_nettype none

module asg_chan (
  input  logic                           clk,
  input  logic                           ctl_rst,
  input  asg_pkg::asg_cfg_t              cfg,
  input  logic                           sw_trg,
  input  logic                           sw_clr,
  input  logic                           trg_in,
  output logic                           trg_out,
  input  asg_pkg::buf_req_t              buf_req,
  output logic signed [asg_pkg::DWO-1:0] buf_rdata,
  output logic signed [asg_pkg::DWO-1:0] sto_dat,
  output logic                           sto_vld
);

  // sample table
  logic signed [asg_pkg::DWO-1:0] mem [0:2**asg_pkg::CWM-1];
  logic [asg_pkg::CWM-1:0]        rd_addr;   // stream read address
  logic signed [asg_pkg::DWO-1:0] rd_data;
  logic                           rd_vld;    // address stage valid

  // pointer, one extra bit for the wrap test
  logic [asg_pkg::CW-1:0] ptr;
  logic [asg_pkg::CW:0]   ptr_add;
  logic [asg_pkg::CW:0]   ptr_sub;

  // burst counters
  logic [15:0] cnt_cyc;
  logic [31:0] cnt_dly;
  logic [15:0] cnt_rep;

  asg_pkg::asg_state_e state;
  logic clr;
  logic trg_start;  // new start from idle
  logic brst_end;   // last cycle of a burst incl. delay
  logic brst_more;  // another burst follows
  logic trg_evt;

  //////////////////////////////////////////////////////////////////////
  // table ram
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (buf_req.ena && buf_req.wen) mem[buf_req.addr] <= buf_req.wdata;
    if (buf_req.ena && !buf_req.wen) buf_rdata <= mem[buf_req.addr];  // cpu read back
  end

  always_ff @(posedge clk) begin
    if (state == asg_pkg::ST_DATA) rd_addr <= ptr[asg_pkg::CWF +: asg_pkg::CWM];
    if (rd_vld) rd_data <= mem[rd_addr];
  end

  //////////////////////////////////////////////////////////////////////
  // trigger and state machine
  //////////////////////////////////////////////////////////////////////

  assign clr = ctl_rst | sw_clr;

  // triggers ignored while running
  assign trg_start = (trg_in | sw_trg) & (state == asg_pkg::ST_IDLE) & ~sw_clr;

  assign brst_end = cfg.brst &
                    (((state == asg_pkg::ST_DATA) && cnt_cyc == '0 && cnt_dly == '0) ||
                     ((state == asg_pkg::ST_DELAY) && cnt_dly == 32'd1));
  assign brst_more = cfg.infn | (cnt_rep > 16'd1);
  assign trg_evt   = trg_start | (brst_end & brst_more & ~sw_clr);
  assign trg_out   = trg_evt;  // every burst start

  always_ff @(posedge clk) begin
    if (clr) begin
      state   <= asg_pkg::ST_IDLE;
      cnt_cyc <= '0;
      cnt_dly <= '0;
      cnt_rep <= '0;
    end else if (trg_evt) begin
      state   <= asg_pkg::ST_DATA;
      cnt_cyc <= cfg.ncyc;
      cnt_dly <= cfg.rdly;
      cnt_rep <= trg_start ? cfg.rnum : cnt_rep - 16'd1;
    end else if (brst_end) begin
      state   <= asg_pkg::ST_IDLE;  // all repetitions done
      cnt_rep <= '0;
    end else if (state == asg_pkg::ST_DATA && cfg.brst) begin
      if (cnt_cyc != '0) cnt_cyc <= cnt_cyc - 16'd1;
      else state <= asg_pkg::ST_DELAY;  // delay is nonzero here
    end else if (state == asg_pkg::ST_DELAY && cnt_dly != '0) begin
      cnt_dly <= cnt_dly - 32'd1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read pointer
  //////////////////////////////////////////////////////////////////////

  assign ptr_add = {1'b0, ptr} + {1'b0, cfg.step};
  assign ptr_sub = ptr_add - {1'b0, cfg.size} - 1'b1;  // negative means no wrap

  always_ff @(posedge clk) begin
    if (clr) begin
      ptr <= '0;
    end else if (trg_evt) begin
      ptr <= cfg.offs;
    end else if (state == asg_pkg::ST_DATA) begin
      ptr <= ptr_sub[asg_pkg::CW] ? ptr_add[asg_pkg::CW-1:0] : ptr_sub[asg_pkg::CW-1:0];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // output stream
  //////////////////////////////////////////////////////////////////////

  // address stage, then data stage
  always_ff @(posedge clk) begin
    if (clr) begin
      rd_vld  <= 1'b0;
      sto_vld <= 1'b0;
    end else begin
      rd_vld  <= state == asg_pkg::ST_DATA;
      sto_vld <= rd_vld;
    end
  end

  assign sto_dat = sto_vld ? rd_data : '0;

endmodule

`default_nettype wire

//--- verilog/asg_top.sv
`timescale 1ns/1ps
`default_nettype none

module asg_top (
  input  logic                           clk,
  input  logic                           ctl_rst,
  input  axil_pkg::axil_req_t            s_axil_req,
  output axil_pkg::axil_rsp_t            s_axil_rsp,
  input  logic                           trg_in,
  output logic                           trg_out,
  output logic signed [asg_pkg::DWO-1:0] sto_dat,
  output logic                           sto_vld
);

  // register block to channel
  asg_pkg::asg_cfg_t              cfg;
  logic                           sw_trg;     // sw trigger pulse
  logic                           sw_clr;     // sw clear pulse
  asg_pkg::buf_req_t              buf_req;    // cpu table access
  logic signed [asg_pkg::DWO-1:0] buf_rdata;

  asg_regs regs0 (
    .clk        (clk),
    .ctl_rst    (ctl_rst),
    .s_axil_req (s_axil_req),
    .s_axil_rsp (s_axil_rsp),
    .cfg        (cfg),
    .sw_trg     (sw_trg),
    .sw_clr     (sw_clr),
    .buf_req    (buf_req),
    .buf_rdata  (buf_rdata)
  );

  asg_chan chan0 (
    .clk       (clk),
    .ctl_rst   (ctl_rst),
    .cfg       (cfg),
    .sw_trg    (sw_trg),
    .sw_clr    (sw_clr),
    .trg_in    (trg_in),
    .trg_out   (trg_out),
    .buf_req   (buf_req),
    .buf_rdata (buf_rdata),
    .sto_dat   (sto_dat),
    .sto_vld   (sto_vld)
  );

endmodule

`default_nettype wire

//--- test/tb_clk.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk (
  output logic clk
);

  initial clk = 1'b0;
  always #4 clk = ~clk;  // 8 ns period

endmodule

`default_nettype wire

//--- test/asg_props.sv
`timescale 1ns/1ps
`default_nettype none

module asg_props (
  input logic                           clk,
  input logic                           ctl_rst,
  input asg_pkg::asg_state_e            state,
  input logic                           brst_end,
  input logic                           trg_out,
  input logic signed [asg_pkg::DWO-1:0] sto_dat,
  input logic                           sto_vld
);

  int fail_cnt = 0;  // read by the testbench at the end

  a_state_legal: assert property (@(posedge clk) disable iff (ctl_rst)
    state inside {asg_pkg::ST_IDLE, asg_pkg::ST_DATA, asg_pkg::ST_DELAY})
    else begin
      $error("channel state outside its enum");
      fail_cnt++;
    end

  // idle stream carries zeros
  a_dat_zero: assert property (@(posedge clk) !sto_vld |-> sto_dat == '0)
    else begin
      $error("sto_dat nonzero while sto_vld low");
      fail_cnt++;
    end

  // start from idle or restart at end of burst, nowhere else
  a_trg_where: assert property (@(posedge clk) disable iff (ctl_rst)
    trg_out |-> (state == asg_pkg::ST_IDLE || brst_end))
    else begin
      $error("trg_out outside idle or burst end");
      fail_cnt++;
    end

endmodule

bind asg_chan asg_props props0 (
  .clk      (clk),
  .ctl_rst  (ctl_rst),
  .state    (state),
  .brst_end (brst_end),
  .trg_out  (trg_out),
  .sto_dat  (sto_dat),
  .sto_vld  (sto_vld)
);

`default_nettype wire

//--- test/asg_tb.sv
`timescale 1ns/1ps
`default_nettype none

module asg_tb;

  localparam int TBL_N  = 64;  // table words loaded
  localparam int WD_CYC = 3 * (16 + 12 * TBL_N + 12 * 40 + 4 * 120 + 3 * 13);

  logic                           clk;
  logic                           ctl_rst;
  axil_pkg::axil_req_t            req;
  axil_pkg::axil_rsp_t            rsp;
  logic                           trg_in;
  logic                           trg_out;
  logic signed [asg_pkg::DWO-1:0] sto_dat;
  logic                           sto_vld;

  logic [asg_pkg::DWO-1:0] mirror [TBL_N];  // copy of the table
  logic [asg_pkg::DWO-1:0] smp_q [$];       // captured stream
  logic [31:0]             lfsr = 32'h8485_47c2;
  int errors  = 0;
  int trg_cnt = 0;
  int cyc     = 0;
  int trg_cyc = 0;  // cycle of first trg_out
  int vld_cyc = 0;  // cycle of first valid sample

  tb_clk clk0 (.clk(clk));

  asg_top dut0 (
    .clk        (clk),
    .ctl_rst    (ctl_rst),
    .s_axil_req (req),
    .s_axil_rsp (rsp),
    .trg_in     (trg_in),
    .trg_out    (trg_out),
    .sto_dat    (sto_dat),
    .sto_vld    (sto_vld)
  );

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32+x^22+x^2+x+1
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp) else begin
      errors++;
      $display("[ERROR] %s: expected %h, got %h", name, exp, got);
    end
  endtask

  // callers start 1 ns after a rising edge
  task automatic axil_write(input logic [15:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
    req.awaddr  = addr;
    req.awvalid = 1'b1;
    req.wdata   = data;
    req.wstrb   = strb;
    req.wvalid  = 1'b1;
    req.bready  = 1'b1;
    @(negedge clk);
    while (!rsp.awready) @(negedge clk);
    @(posedge clk);
    #1;
    req.awvalid = 1'b0;
    req.wvalid  = 1'b0;
    @(negedge clk);
    while (!rsp.bvalid) @(negedge clk);
    check_val("write_resp", axil_pkg::OKAY, rsp.bresp);
    @(posedge clk);
    #1;
    req.bready = 1'b0;
  endtask

  task automatic axil_read(input logic [15:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    req.araddr  = addr;
    req.arvalid = 1'b1;
    @(negedge clk);
    while (!rsp.arready) @(negedge clk);
    @(posedge clk);
    #1;
    req.arvalid = 1'b0;
    req.rready  = 1'b1;
    @(negedge clk);
    while (!rsp.rvalid) @(negedge clk);
    data = rsp.rdata;
    resp = rsp.rresp;
    @(posedge clk);
    #1;
    req.rready = 1'b0;
  endtask

  task automatic load_table();
    logic [asg_pkg::DWO-1:0] v;
    for (int i = 0; i < TBL_N; i++) begin
      for (int b = 0; b < asg_pkg::DWO; b++) begin
        lfsr = lfsr_step(lfsr);
        v    = {v[asg_pkg::DWO-2:0], lfsr[0]};  // one step per bit
      end
      mirror[i] = v;
      axil_write(16'(asg_pkg::BUF_BASE + 4 * i), 32'(v), 4'hf);
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic pulse_trg_in();
    trg_in = 1'b1;
    @(posedge clk);
    #1;
    trg_in = 1'b0;
  endtask

  task automatic clear_capture();
    smp_q.delete();
    trg_cnt = 0;
  endtask

  task automatic wait_samples(input string name, input int n);
    int k;
    k = 0;
    while (smp_q.size() < n && k < 4 * n + 64) begin
      @(posedge clk);
      k++;
    end
    #1;
    if (smp_q.size() < n) begin
      errors++;
      $display("%s: stream stopped before %0d samples arrived", name, n);
    end
  endtask

  // expected stream, pointer from offs, modulo size+1
  task automatic check_stream(input string name, input int first, input int n,
                              input logic [31:0] offs, input logic [31:0] step,
                              input logic [31:0] size);
    logic [31:0] p;
    p = offs;
    for (int i = 0; i < n; i++) begin
      check_val(name, 32'(mirror[p >> 16]), 32'(smp_q[first + i]));
      p = p + step;
      if (p > size) p = p - size - 1;
    end
  endtask

  task automatic set_play(input logic [31:0] mode, input logic [31:0] offs,
                          input logic [31:0] step);
    axil_write(asg_pkg::REG_MODE, mode, 4'hf);
    axil_write(asg_pkg::REG_SIZE, 32'h000f_ffff, 4'hf);  // 16 entries
    axil_write(asg_pkg::REG_OFFS, offs, 4'hf);
    axil_write(asg_pkg::REG_STEP, step, 4'hf);
  endtask

  //////////////////////////////////////////////////////////////////////
  // stream monitor, first sample lags trigger by 3
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    cyc++;
    if (trg_out) begin
      if (trg_cnt == 0) trg_cyc = cyc;
      trg_cnt++;
    end
    if (sto_vld) begin
      if (smp_q.size() == 0) vld_cyc = cyc;
      smp_q.push_back(sto_dat);
    end
  end

  a_trg_lat: assert property (@(posedge clk) disable iff (ctl_rst || dut0.chan0.sw_clr)
    trg_out |-> ##3 sto_vld)
    else begin
      errors++;
      $display("no valid sample 3 cycles after a trigger pulse");
    end

  initial begin
    #(WD_CYC * 8);
    $display("timeout, the run did not finish in time");
    $display("Simulation finished: FAIL");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [15:0] ra [7];
    logic [31:0] rv [7];
    logic [31:0] rd;
    logic [1:0]  rs;
    req     = '0;
    trg_in  = 1'b0;
    ctl_rst = 1'b1;
    repeat (16) @(posedge clk);
    #1;
    ctl_rst = 1'b0;
    idle_cycles(2);

    // register and table access
    ra = '{asg_pkg::REG_MODE, asg_pkg::REG_SIZE, asg_pkg::REG_STEP, asg_pkg::REG_OFFS,
           asg_pkg::REG_NCYC, asg_pkg::REG_RNUM, asg_pkg::REG_RDLY};
    rv = '{32'h3, 32'h0123_4567, 32'h0005_8000, 32'h02ab_cdef,
           32'h0000_beef, 32'h0000_1234, 32'hdead_beef};
    for (int i = 0; i < 7; i++) axil_write(ra[i], rv[i], 4'hf);
    for (int i = 0; i < 7; i++) begin
      axil_read(ra[i], rd, rs);
      check_val("reg_readback", rv[i], rd);
      check_val("reg_resp", axil_pkg::OKAY, rs);
    end
    axil_write(asg_pkg::REG_RDLY, 32'h1111_2233, 4'b0010);  // byte 1 only
    axil_read(asg_pkg::REG_RDLY, rd, rs);
    check_val("strobe_merge", 32'hdead_22ef, rd);
    axil_read(16'h0040, rd, rs);
    check_val("unmapped_resp", axil_pkg::SLVERR, rs);
    load_table();
    for (int i = 0; i < 8; i++) begin
      axil_read(16'(asg_pkg::BUF_BASE + 4 * i), rd, rs);
      check_val("table_readback", {{18{mirror[i][13]}}, mirror[i]}, rd);
      check_val("table_resp", axil_pkg::OKAY, rs);
    end

    // continuous playback with wrap, step 3.5
    set_play(32'h0, 32'h0001_0000, 32'h0003_8000);
    clear_capture();
    axil_write(asg_pkg::REG_CTRL, 32'h1, 4'hf);
    wait_samples("continuous", 40);
    axil_write(asg_pkg::REG_CTRL, 32'h2, 4'hf);
    check_val("trg_latency", 32'd3, 32'(vld_cyc - trg_cyc));
    check_stream("continuous", 0, 40, 32'h0001_0000, 32'h0003_8000, 32'h000f_ffff);
    idle_cycles(8);

    // three bursts of eight
    set_play(32'h1, 32'h0002_0000, 32'h0001_0000);
    axil_write(asg_pkg::REG_NCYC, 32'd7, 4'hf);
    axil_write(asg_pkg::REG_RNUM, 32'd3, 4'hf);
    axil_write(asg_pkg::REG_RDLY, 32'd5, 4'hf);
    clear_capture();
    axil_write(asg_pkg::REG_CTRL, 32'h1, 4'hf);
    wait_samples("burst", 24);
    idle_cycles(40);
    check_val("burst_samples", 32'd24, 32'(smp_q.size()));
    check_val("burst_trg_out", 32'd3, 32'(trg_cnt));
    check_val("burst_idle", asg_pkg::ST_IDLE, dut0.chan0.state);
    for (int b = 0; b < 3; b++)
      check_stream("burst", 8 * b, 8, 32'h0002_0000, 32'h0001_0000, 32'h000f_ffff);

    // external trigger, second pulse ignored
    set_play(32'h0, 32'h0005_4000, 32'h0001_8000);
    clear_capture();
    pulse_trg_in();
    wait_samples("ext_trigger", 10);
    pulse_trg_in();
    wait_samples("ext_trigger", 30);
    check_val("ext_trg_out", 32'd1, 32'(trg_cnt));
    check_stream("ext_trigger", 0, 30, 32'h0005_4000, 32'h0001_8000, 32'h000f_ffff);
    axil_write(asg_pkg::REG_CTRL, 32'h2, 4'hf);
    idle_cycles(8);

    // clear during infinite bursts
    set_play(32'h3, 32'h0, 32'h0001_0000);
    clear_capture();
    axil_write(asg_pkg::REG_CTRL, 32'h1, 4'hf);
    wait_samples("clear", 30);
    axil_write(asg_pkg::REG_CTRL, 32'h2, 4'hf);
    @(negedge clk);
    check_val("clear_drop", 32'd0, 32'(sto_vld));
    @(posedge clk);
    #1;
    clear_capture();
    idle_cycles(50);
    check_val("clear_samples", 32'd0, 32'(smp_q.size()));
    check_val("clear_trg_out", 32'd0, 32'(trg_cnt));

    errors += dut0.chan0.props0.fail_cnt;
    $display("checks done, errors: %0d", errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- asg.f
verilog/axil_pkg.sv
verilog/asg_pkg.sv
verilog/asg_regs.sv
verilog/asg_chan.sv
verilog/asg_top.sv
test/tb_clk.sv
test/asg_props.sv
test/asg_tb.sv

//--- Bender.yml
package:
  name: asg

sources:
  - verilog/axil_pkg.sv
  - verilog/asg_pkg.sv
  - verilog/asg_regs.sv
  - verilog/asg_chan.sv
  - verilog/asg_top.sv
  - target: test
    files:
      - test/tb_clk.sv
      - test/asg_props.sv
      - test/asg_tb.sv
